/* imager_ctrl.f */
src/imager_pkg.sv
src/pixel_pkg.sv
src/host_regs.sv
src/pattern_store.sv
src/exposure_seq.sv
src/pixel_packer.sv
src/frame_fifo.sv
src/imager_top.sv
bench/clk_gen.sv
bench/tb_imager.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the imager testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_imager \
	-f imager_ctrl.f -o sim_imager
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_imager > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Verification passed" "$LOG"; then
	exit 0
fi
exit 1

/* bench/tb_imager.sv */
`timescale 1ns/10ps

module tb_imager import imager_pkg::*, pixel_pkg::*; ();

	// cycle budget per test and a run limit of twice the sum
	localparam int T_PACK = 150;
	localparam int T_FLAGS = 420;
	localparam int T_PATTERN = 150;
	localparam int T_STOP = 260;
	localparam int T_SOFT = 250;
	localparam int CYCLE_LIMIT = 2 * (8 + T_PACK + T_FLAGS + T_PATTERN + T_STOP + T_SOFT);
	localparam int EXPOSURE = 7; // subframe length in cycles

	logic               CLK_HS;
	logic               rst_n;
	host_wr_t           host_wr;
	logic [PIX_W-1:0]   im_data;
	logic               im_data_val, expose_req, buf_rd;
	logic [WORD_W-1:0]  rd_data;
	buf_status_t        status;
	logic               stream, drain_b, pixres_glob;
	logic [PAT_W-1:0]   mstream;
	logic [7:0]         led;

	logic [PIX_W-1:0]  pix_sent[$];  // samples the packer must keep
	logic [WORD_W-1:0] exp_words[$]; // words still to come out
	logic [PAT_W-1:0]  pat_sent[$];  // patterns now in the store, in order
	int  num_pat_set;
	bit  pat_check_en, stop_check_en;
	int  err_cnt, mon_errs, test_base, tests_run, tests_failed;
	int  cycle;
	int  drain_cnt = 0, frame_sub = 0, last_stream = 0;
	logic stream_d = 1'b0, drain_d = 1'b1, two_frames_d = 1'b0; // last falling edge

	clk_gen u_clk (.CLK_HS(CLK_HS), .rst_n(rst_n));

	imager_top UUT (
		.CLK_HS(CLK_HS), .rst_n(rst_n), .host_wr(host_wr), .im_data(im_data),
		.im_data_val(im_data_val), .expose_req(expose_req), .buf_rd(buf_rd),
		.rd_data(rd_data), .status(status), .stream(stream), .mstream(mstream),
		.drain_b(drain_b), .pixres_glob(pixres_glob), .led(led)
	);

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////
	// word k from the kept samples with the first one in the low byte
	function automatic logic [WORD_W-1:0] packed_word(int k);
		logic [WORD_W-1:0] w;
		for (int i = 0; i < PIX_PER_WORD; i++)
			w[i*PIX_W +: PIX_W] = pix_sent[k*PIX_PER_WORD + i];
		return w;
	endfunction

	function automatic logic [PAT_W-1:0] expected_pattern(int k);
		return pat_sent[k % pat_sent.size()]; // subframes walk the store from 0
	endfunction

	////////////////////////////////////////
	// stimulus tasks
	////////////////////////////////////////
	task automatic host_write(logic [7:0] addr, logic [31:0] data);
		@(posedge CLK_HS);
		host_wr.stb  <= 1'b1;
		host_wr.addr <= addr;
		host_wr.data <= data;
		@(posedge CLK_HS);
		host_wr.stb <= 1'b0; // one cycle strobe
	endtask

	task automatic push_pattern(logic [PAT_W-1:0] p);
		pat_sent.push_back(p);
		host_write(PIPE_PATTERN, 32'(p));
	endtask

	// sensor bytes with keep set when the packer should hold them
	task automatic send_samples(int n, bit gaps, bit keep);
		logic [PIX_W-1:0] s;
		for (int i = 0; i < n; i++) begin
			s = PIX_W'($urandom);
			@(posedge CLK_HS);
			im_data_val <= 1'b0;
			if (gaps)
				repeat ($urandom_range(2, 0)) @(posedge CLK_HS); // idle gap
			im_data_val <= 1'b1;
			im_data     <= s;
			if (keep)
				pix_sent.push_back(s);
		end
		@(posedge CLK_HS);
		im_data_val <= 1'b0;
	endtask

	// queue reference words and then read one per cycle
	task automatic read_words(int n);
		for (int k = 0; k < n; k++)
			exp_words.push_back(packed_word(k));
		pix_sent.delete();
		@(posedge CLK_HS);
		buf_rd <= 1'b1;
		repeat (n) @(posedge CLK_HS);
		buf_rd <= 1'b0;
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		assert (got === exp) else begin
			$display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	// mask bit order is frame_ready then two_frames then empty
	task automatic wait_flag(logic [2:0] mask, int limit, string what);
		int n = 0;
		@(negedge CLK_HS);
		while ((status & mask) != mask && n < limit) begin
			@(negedge CLK_HS);
			n++;
		end
		assert ((status & mask) == mask) else begin
			$display("at %0t: %s did not rise within %0d cycles", $time, what, limit);
			err_cnt++;
		end
	endtask

	// back to back frames until n drain cycles are seen
	task automatic run_frames(int n);
		int base;
		int k = 0;
		base = drain_cnt;
		pat_check_en = 1'b1;
		@(posedge CLK_HS);
		expose_req <= 1'b1;
		while (drain_cnt < base + n && k < n * 60) begin
			@(posedge CLK_HS);
			k++;
		end
		expose_req <= 1'b0;
		assert (drain_cnt >= base + n) else begin
			$display("at %0t: %0d frames did not complete", $time, n);
			err_cnt++;
		end
		repeat (2) @(posedge CLK_HS);
		pat_check_en = 1'b0;
	endtask

	task automatic end_test(string name);
		int errs;
		errs = err_cnt + mon_errs - test_base;
		$display("test %0d %s: %s, %0d errors", tests_run + 1, name,
			(errs == 0) ? "ok" : "FAIL", errs);
		if (errs != 0)
			tests_failed++;
		tests_run++;
		test_base = err_cnt + mon_errs;
	endtask

	////////////////////////////////////////
	// comparing process sampling outputs at the falling edge
	////////////////////////////////////////
	always @(negedge CLK_HS) begin
		logic [WORD_W-1:0] exp_w;
		seq_state_t        exp_state;
		if (rst_n) begin
			if (buf_rd) begin
				assert (exp_words.size() > 0) else begin
					$display("at %0t: host read with no word expected", $time);
					mon_errs++;
				end
				if (exp_words.size() > 0) begin
					exp_w = exp_words.pop_front();
					assert (rd_data === exp_w) else begin
						$display("FAILED at %0t: rd_data got %h expected %h", $time, rd_data, exp_w);
						mon_errs++;
					end
				end
			end
			// leds carry the FSM state implied by the control outputs
			if (pixres_glob)
				exp_state = SEQ_IDLE;
			else if (stream)
				exp_state = SEQ_LOAD;
			else if (!drain_b)
				exp_state = SEQ_DRAIN;
			else
				exp_state = SEQ_EXPOSE;
			assert (led === {6'd0, exp_state}) else begin
				$display("FAILED at %0t: led got %h expected %h", $time, led,
					{6'd0, exp_state});
				mon_errs++;
			end
			if (pat_check_en) begin
				if (stream_d) // mstream settles the cycle after the strobe
					assert (mstream === expected_pattern(frame_sub - 1)) else begin
						$display("FAILED at %0t: mstream got %h expected %h", $time, mstream,
							expected_pattern(frame_sub - 1));
						mon_errs++;
					end
				if (stream) begin
					if (frame_sub > 0)
						assert (cycle - last_stream == EXPOSURE + 1) else begin
							$display("FAILED at %0t: stream spacing got %0d expected %0d", $time,
								cycle - last_stream, EXPOSURE + 1);
							mon_errs++;
						end
					last_stream = cycle;
					frame_sub++;
				end
				if (!drain_b) begin
					assert (drain_d) else begin
						$display("at %0t: drain_b low for more than one cycle", $time);
						mon_errs++;
					end
					assert (frame_sub == num_pat_set) else begin
						$display("FAILED at %0t: subframes got %0d expected %0d", $time,
							frame_sub, num_pat_set);
						mon_errs++;
					end
					frame_sub = 0;
					drain_cnt++;
				end
			end else begin
				frame_sub = 0;
			end
			if (stop_check_en && status.two_frames && !two_frames_d)
				assert (!pixres_glob) else begin
					$display("at %0t: sequencer idle when the buffer filled", $time);
					mon_errs++;
				end
			if (stop_check_en && two_frames_d) begin // stop seen at the last edge
				assert (pixres_glob === 1'b1) else begin
					$display("FAILED at %0t: pixres_glob got %b expected 1", $time, pixres_glob);
					mon_errs++;
				end
				assert (stream === 1'b0) else begin
					$display("at %0t: stream pulse while two frames are buffered", $time);
					mon_errs++;
				end
			end
		end
		stream_d     = stream;
		drain_d      = drain_b;
		two_frames_d = status.two_frames;
	end

	// run limit
	always @(posedge CLK_HS) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles, a test did not finish", cycle);
			$display("Verification failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////
	initial begin
		void'($urandom(32'h3ca5_f03e));
		host_wr     <= '0;
		im_data     <= '0;
		im_data_val <= 1'b0;
		expose_req  <= 1'b0;
		buf_rd      <= 1'b0;
		wait (rst_n === 1'b1);
		@(posedge CLK_HS);

		send_samples(30, 1'b1, 1'b1); // ten words with random gaps
		@(posedge CLK_HS);
		read_words(10);
		@(negedge CLK_HS);
		check_bit("empty", status.empty, 1'b1);
		end_test("packing");

		send_samples(47, 1'b1, 1'b1); // one sample short of a frame
		repeat (2) @(posedge CLK_HS);
		@(negedge CLK_HS);
		check_bit("frame_ready", status.frame_ready, 1'b0);
		send_samples(1, 1'b0, 1'b1);
		wait_flag(3'b100, 3, "frame_ready");
		send_samples(48, 1'b1, 1'b1);
		wait_flag(3'b010, 3, "two_frames");
		send_samples(12, 1'b1, 1'b0); // all dropped while two frames are held
		repeat (2) @(posedge CLK_HS);
		read_words(32);
		@(negedge CLK_HS);
		check_bit("empty", status.empty, 1'b1);
		check_bit("frame_ready", status.frame_ready, 1'b0);
		check_bit("two_frames", status.two_frames, 1'b0);
		end_test("buffer flags");

		for (int i = 0; i < 5; i++)
			push_pattern(PAT_W'($urandom));
		num_pat_set = 5;
		host_write(REG_NUM_PAT, 32'd5);
		host_write(REG_EXPOSURE, EXPOSURE);
		run_frames(2);
		end_test("pattern sequence");

		stop_check_en = 1'b1;
		@(posedge CLK_HS);
		expose_req <= 1'b1;
		do @(negedge CLK_HS); while (pixres_glob === 1'b1); // first frame under way
		send_samples(96, 1'b0, 1'b1);
		wait_flag(3'b010, 3, "two_frames");
		repeat (12) @(posedge CLK_HS); // sequencer must stay idle
		expose_req <= 1'b0;
		@(posedge CLK_HS);
		read_words(32);
		stop_check_en = 1'b0;
		@(negedge CLK_HS);
		check_bit("empty", status.empty, 1'b1);
		end_test("sequencer stop");

		push_pattern(PAT_W'($urandom)); // pointer now past the old list
		send_samples(31, 1'b1, 1'b0);   // stray byte left in the packer
		repeat (2) @(posedge CLK_HS);
		host_write(REG_CTRL, 32'd1);
		host_write(REG_CTRL, 32'd0);
		@(negedge CLK_HS);
		check_bit("empty", status.empty, 1'b1);
		check_bit("frame_ready", status.frame_ready, 1'b0);
		check_bit("two_frames", status.two_frames, 1'b0);
		pat_sent.delete();
		for (int i = 0; i < 3; i++)
			push_pattern(PAT_W'($urandom));
		num_pat_set = 3;
		host_write(REG_NUM_PAT, 32'd3);
		run_frames(1);
		send_samples(6, 1'b1, 1'b1);
		@(posedge CLK_HS);
		read_words(2);
		@(negedge CLK_HS);
		check_bit("empty", status.empty, 1'b1);
		end_test("soft reset");

		$display("%0d tests run, %0d failed, %0d errors in all", tests_run, tests_failed,
			err_cnt + mon_errs);
		if (err_cnt + mon_errs == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* bench/clk_gen.sv */
`timescale 1ns/10ps

module clk_gen (
	output logic CLK_HS,
	output logic rst_n
);

	localparam int HALF_NS = 2; // 4 ns period

	initial begin
		CLK_HS = 1'b0;
		forever #HALF_NS CLK_HS = ~CLK_HS;
	end

	// reset low for 8 rising edges
	initial begin
		rst_n <= 1'b0;
		repeat (8) @(posedge CLK_HS);
		rst_n <= 1'b1;
	end

endmodule

/* src/imager_top.sv */
`timescale 1ns/10ps

module imager_top import imager_pkg::*; import pixel_pkg::*; (
	input  logic               CLK_HS,
	input  logic               rst_n,
	input  host_wr_t           host_wr,
	input  logic [PIX_W-1:0]   im_data,
	input  logic               im_data_val,
	input  logic               expose_req,
	input  logic               buf_rd,
	output logic [WORD_W-1:0]  rd_data,
	output buf_status_t        status,
	output logic               stream,
	output logic [PAT_W-1:0]   mstream,
	output logic               drain_b,
	output logic               pixres_glob,
	output logic [7:0]         led
);

	imager_cfg_t        cfg;
	logic               pat_push;
	logic [PAT_W-1:0]   pat_data;
	logic [PAT_AW-1:0]  rd_idx;
	logic [PAT_W-1:0]   rd_pat;
	seq_state_t         seq_state;
	logic               seq_stop;
	logic               word_wr;
	logic [WORD_W-1:0]  word;

	// halt exposures on soft reset or when the host falls two frames behind
	assign seq_stop = cfg.soft_rst | status.two_frames;
	assign led      = {6'd0, seq_state}; // FSM state on the board leds

	////////////////////////////////////////
	// host and pattern side
	////////////////////////////////////////
	host_regs u_regs (
		.CLK_HS(CLK_HS), .rst_n(rst_n), .host_wr(host_wr),
		.cfg(cfg), .pat_push(pat_push), .pat_data(pat_data)
	);

	pattern_store u_pat (
		.CLK_HS(CLK_HS), .rst_n(rst_n), .clear(cfg.soft_rst),
		.pat_push(pat_push), .pat_data(pat_data), .rd_idx(rd_idx), .rd_pat(rd_pat)
	);

	exposure_seq u_seq (
		.CLK_HS(CLK_HS), .rst_n(rst_n), .stop(seq_stop), .expose_req(expose_req),
		.exposure(cfg.exposure), .num_pat(cfg.num_pat), .rd_idx(rd_idx), .rd_pat(rd_pat),
		.stream(stream), .drain_b(drain_b), .pixres_glob(pixres_glob),
		.mstream(mstream), .state(seq_state)
	);

	////////////////////////////////////////
	// pixel side
	////////////////////////////////////////
	pixel_packer u_pack (
		.CLK_HS(CLK_HS), .rst_n(rst_n), .clear(cfg.soft_rst), .im_data(im_data),
		.im_data_val(im_data_val), .status(status), .word_wr(word_wr), .word(word)
	);

	frame_fifo u_buf (
		.CLK_HS(CLK_HS), .rst_n(rst_n), .clear(cfg.soft_rst), .word_wr(word_wr),
		.word(word), .buf_rd(buf_rd), .rd_data(rd_data), .status(status)
	);

endmodule

/* src/frame_fifo.sv */
`timescale 1ns/10ps

module frame_fifo import pixel_pkg::*; (
	input  logic               CLK_HS,
	input  logic               rst_n,
	input  logic               clear,
	input  logic               word_wr,
	input  logic [WORD_W-1:0]  word,
	input  logic               buf_rd,
	output logic [WORD_W-1:0]  rd_data,
	output buf_status_t        status
);

	logic [WORD_W-1:0] mem [BUF_DEPTH];
	logic [BUF_AW-1:0] wr_ptr;
	logic [BUF_AW-1:0] rd_ptr;
	logic [BUF_AW:0]   count; // words held, 0..BUF_DEPTH
	logic              push;
	logic              pop;

	assign push = word_wr && (count != BUF_DEPTH); // never reached, packer stops at 2 frames
	assign pop  = buf_rd && (count != '0);         // read on empty ignored

	// first word fall through, oldest word always on the port
	assign rd_data = mem[rd_ptr];

	////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////
	always_ff @(posedge CLK_HS or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	always_ff @(posedge CLK_HS) begin
		if (push && !clear) begin
			mem[wr_ptr] <= word;
		end
	end

	// levels straight from the count
	assign status.frame_ready = (count >= FRAME_WORDS);
	assign status.two_frames  = (count >= 2 * FRAME_WORDS);
	assign status.empty       = (count == '0);

endmodule

/* src/pixel_packer.sv */
`timescale 1ns/10ps

module pixel_packer import pixel_pkg::*; (
	input  logic               CLK_HS,
	input  logic               rst_n,
	input  logic               clear,
	input  logic [PIX_W-1:0]   im_data,
	input  logic               im_data_val,
	input  buf_status_t        status,
	output logic               word_wr,
	output logic [WORD_W-1:0]  word
);

	logic [WORD_W-1:0]                 sh;     // shifts right, first sample ends low
	logic [$clog2(PIX_PER_WORD)-1:0]   cnt;    // samples held so far
	logic                              accept; // sample taken this cycle

	assign accept = im_data_val && !status.two_frames; // drop while two frames held
	assign word   = sh; // complete only while word_wr is high

	////////////////////////////////////////
	// sample counter and word strobe
	////////////////////////////////////////
	always_ff @(posedge CLK_HS or negedge rst_n) begin
		if (!rst_n) begin
			cnt     <= '0;
			word_wr <= 1'b0;
		end else if (clear || status.two_frames) begin
			cnt     <= '0; // partial word abandoned
			word_wr <= 1'b0;
		end else begin
			word_wr <= accept && (cnt == PIX_PER_WORD - 1);
			if (accept) begin
				cnt <= (cnt == PIX_PER_WORD - 1) ? '0 : cnt + 1'b1;
			end
		end
	end

	// byte shift register
	always_ff @(posedge CLK_HS) begin
		if (accept) begin
			sh <= {im_data, sh[WORD_W-1:PIX_W]};
		end
	end

endmodule

/* src/exposure_seq.sv */
`timescale 1ns/10ps

module exposure_seq import imager_pkg::*; (
	input  logic               CLK_HS,
	input  logic               rst_n,
	input  logic               stop,       // soft reset or buffer at two frames
	input  logic               expose_req, // level, frames run back to back
	input  logic [15:0]        exposure,
	input  logic [PAT_AW:0]    num_pat,
	output logic [PAT_AW-1:0]  rd_idx,
	input  logic [PAT_W-1:0]   rd_pat,
	output logic               stream,
	output logic               drain_b,
	output logic               pixres_glob,
	output logic [PAT_W-1:0]   mstream,
	output seq_state_t         state
);

	logic [15:0]     exp_q;   // exposure latched at frame start
	logic [15:0]     exp_cnt; // cycles left in this subframe
	logic [PAT_AW:0] num_q;   // subframes latched at frame start
	logic [PAT_AW:0] sub_cnt; // next pattern index

	// store address runs one subframe ahead, data ready in LOAD
	assign rd_idx      = sub_cnt[PAT_AW-1:0];
	assign stream      = (state == SEQ_LOAD);
	assign drain_b     = (state != SEQ_DRAIN); // active low
	assign pixres_glob = (state == SEQ_IDLE);

	////////////////////////////////////////
	// subframe FSM
	////////////////////////////////////////
	always_ff @(posedge CLK_HS or negedge rst_n) begin
		if (!rst_n) begin
			state   <= SEQ_IDLE;
			exp_q   <= '0;
			exp_cnt <= '0;
			num_q   <= '0;
			sub_cnt <= '0;
			mstream <= '0;
		end else begin
			if (state == SEQ_LOAD) begin
				mstream <= rd_pat; // held for the whole subframe
			end
			if (stop) begin
				state   <= SEQ_IDLE; // abort, next frame starts from pattern 0
				sub_cnt <= '0;
			end else begin
				case (state)
					SEQ_IDLE: begin
						if (expose_req && (num_pat != '0)) begin
							exp_q <= (exposure == '0) ? 16'd1 : exposure; // at least 1 cycle
							num_q <= num_pat;
							state <= SEQ_LOAD;
						end
					end
					SEQ_LOAD: begin
						exp_cnt <= exp_q;
						sub_cnt <= sub_cnt + 1'b1;
						state   <= SEQ_EXPOSE;
					end
					SEQ_EXPOSE: begin
						if (exp_cnt == 16'd1) begin
							if (sub_cnt == num_q) begin
								sub_cnt <= '0; // last subframe done
								state   <= SEQ_DRAIN;
							end else begin
								state <= SEQ_LOAD;
							end
						end else begin
							exp_cnt <= exp_cnt - 1'b1;
						end
					end
					default: begin
						state <= SEQ_IDLE; // drain is a single cycle
					end
				endcase
			end
		end
	end

endmodule

/* src/pattern_store.sv */
`timescale 1ns/10ps

module pattern_store import imager_pkg::*; (
	input  logic               CLK_HS,
	input  logic               rst_n,
	input  logic               clear,    // soft reset, pointer back to 0
	input  logic               pat_push,
	input  logic [PAT_W-1:0]   pat_data,
	input  logic [PAT_AW-1:0]  rd_idx,
	output logic [PAT_W-1:0]   rd_pat
);

	logic [PAT_W-1:0]  mem [PAT_DEPTH]; // mask list
	logic [PAT_AW-1:0] wr_ptr;

	////////////////////////////////////////
	// host side write pointer
	////////////////////////////////////////
	always_ff @(posedge CLK_HS or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
		end else if (clear) begin
			wr_ptr <= '0; // old entries stay until overwritten
		end else if (pat_push) begin
			wr_ptr <= wr_ptr + 1'b1; // wraps at PAT_DEPTH
		end
	end

	always_ff @(posedge CLK_HS) begin
		if (pat_push && !clear) begin
			mem[wr_ptr] <= pat_data;
		end
	end

	// sequencer read, one cycle latency
	always_ff @(posedge CLK_HS) begin
		rd_pat <= mem[rd_idx];
	end

endmodule

/* src/host_regs.sv */
`timescale 1ns/10ps

module host_regs import imager_pkg::*; (
	input  logic              CLK_HS,
	input  logic              rst_n,
	input  host_wr_t          host_wr,
	output imager_cfg_t       cfg,
	output logic              pat_push,
	output logic [PAT_W-1:0]  pat_data
);

	logic pat_sel; // strobed write to the pattern pipe

	assign pat_sel = host_wr.stb && (host_wr.addr == PIPE_PATTERN);

	////////////////////////////////////////
	// config registers and push pulse
	////////////////////////////////////////
	always_ff @(posedge CLK_HS or negedge rst_n) begin
		if (!rst_n) begin
			cfg      <= '0;
			pat_push <= 1'b0;
		end else begin
			pat_push <= pat_sel; // single cycle, one per write
			if (host_wr.stb) begin
				case (host_wr.addr)
					REG_CTRL: begin
						cfg.soft_rst <= host_wr.data[0];
					end
					REG_EXPOSURE: begin
						cfg.exposure <= host_wr.data[15:0];
					end
					REG_NUM_PAT: begin
						cfg.num_pat <= host_wr.data[PAT_AW:0];
					end
					default: begin
						// pattern pipe handled above, anything else dropped
					end
				endcase
			end
		end
	end

	// pattern payload, valid with pat_push
	always_ff @(posedge CLK_HS) begin
		if (pat_sel) begin
			pat_data <= host_wr.data[PAT_W-1:0]; // upper bits ignored
		end
	end

endmodule

/* src/pixel_pkg.sv */
package pixel_pkg;

	// sensor samples and packed words
	localparam int PIX_W        = 8;
	localparam int PIX_PER_WORD = 3;
	localparam int WORD_W       = 24; // PIX_W * PIX_PER_WORD

	////////////////////////////////////////
	// frame buffer
	////////////////////////////////////////
	localparam int FRAME_WORDS = 16;  // words per frame
	localparam int BUF_DEPTH   = 64;
	localparam int BUF_AW      = 6;

	// levels seen by the host and the packer
	typedef struct packed {
		logic frame_ready; // at least one frame buffered
		logic two_frames;  // two frames held, writes stop
		logic empty;
	} buf_status_t;

endpackage

/* src/imager_pkg.sv */
package imager_pkg;

	////////////////////////////////////////
	// host register map
	////////////////////////////////////////
	localparam logic [7:0] REG_CTRL     = 8'h10; // bit 0 soft reset
	localparam logic [7:0] REG_EXPOSURE = 8'h11; // cycles per subframe
	localparam logic [7:0] REG_NUM_PAT  = 8'h12; // subframes per frame
	localparam logic [7:0] PIPE_PATTERN = 8'h80; // pattern push, low bits only

	// mask pattern sizes
	localparam int PAT_W     = 10;
	localparam int PAT_DEPTH = 64;
	localparam int PAT_AW    = 6;

	// one host write, 41 bits
	typedef struct packed {
		logic        stb;
		logic [7:0]  addr;
		logic [31:0] data;
	} host_wr_t;

	// live configuration, 24 bits
	typedef struct packed {
		logic              soft_rst;
		logic [15:0]       exposure;
		logic [PAT_AW:0]   num_pat;  // one extra bit so a full store fits
	} imager_cfg_t;

	////////////////////////////////////////
	// exposure sequencer
	////////////////////////////////////////
	typedef enum logic [1:0] {
		SEQ_IDLE,   // pixels held in global reset
		SEQ_LOAD,   // one cycle, stream strobe
		SEQ_EXPOSE, // exposure countdown
		SEQ_DRAIN   // one cycle drain after last subframe
	} seq_state_t;

endpackage
